// ==== sim.f ====
hw/cpuPkg.sv
hw/hazardDetector.sv
hw/regFile.sv
hw/aluUnit.sv
hw/pipelineCore.sv
hw/dataMemory.sv
hw/cpuTop.sv
testbench/cpuTb.sv

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	localparam int memDepth = 64;
	// 60 random instructions plus HALT
	localparam int progLen = 61;
	localparam int haltLimit = 1000;
	localparam int quietCycles = 20;

	logic clk;
	logic rst;
	logic [dataWidth-1:0] instrAddr;
	logic [dataWidth-1:0] instrData;
	logic wbValid;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0] wbData;
	logic halted;

	integer seed;
	int wbCount;
	int modelWrites;
	logic [dataWidth-1:0] prog [progLen];
	// Architectural state of the reference model
	logic [dataWidth-1:0] modelRegs [8];
	logic [dataWidth-1:0] modelMem [memDepth];
	// Expected writeback stream in program order
	logic [regAddrWidth-1:0] expReg [$];
	logic [dataWidth-1:0] expData [$];

	cpuTop #(
		.dataDepth(memDepth)
	) UUT (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// Instruction ROM returns NOP past the end
	always_comb begin
		if ($isunknown(instrAddr) || instrAddr >= progLen) begin
			instrData = {opNop, 11'b0};
		end else begin
			instrData = prog[instrAddr];
		end
	end

	function automatic int randBelow(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Fail time=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic abortRun(input string why);
		$display("%s at time %0t", why, $time);
		$display("TEST FAIL");
		$fatal(1, "%s", why);
	endtask

	// Random program with dependency chains and store/load pairs
	task automatic buildProgram;
		logic [opWidth-1:0] op;
		logic [regAddrWidth-1:0] rs, rt, rd, lastDest;
		logic [4:0] imm;
		logic lastWrote, lastWasSt, isRType;
		logic [dataWidth-1:0] lastSt;
		lastDest = '0;
		lastWrote = 1'b0;
		lastWasSt = 1'b0;
		lastSt = '0;
		for (int i = 0; i < progLen - 1; i++) begin
			rs = randBelow(8);
			rt = randBelow(8);
			rd = randBelow(8);
			imm = randBelow(32);
			case (randBelow(12))
				0: op = opAdd;
				1: op = opSub;
				2: op = opAnd;
				3: op = opXor;
				4, 5, 6: op = opAddi;
				7, 8: op = opLd;
				9, 10: op = opSt;
				default: op = opNop;
			endcase
			// Read what the instruction just before wrote
			if (lastWrote && randBelow(2) == 0) begin
				rs = lastDest;
			end
			if (lastWrote && randBelow(4) == 0) begin
				rt = lastDest;
			end
			// Same base and offset as the store before
			if (lastWasSt && randBelow(2) == 0) begin
				op = opLd;
				rs = lastSt[rsMsb:rsLsb];
				imm = lastSt[4:0];
			end
			isRType = (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opXor);
			if (isRType) begin
				prog[i] = {op, rs, rt, rd, imm[1:0]};
			end else begin
				prog[i] = {op, rs, rt, imm};
			end
			lastWasSt = (op == opSt);
			lastSt = prog[i];
			lastWrote = isRType || (op == opAddi) || (op == opLd);
			lastDest = isRType ? rd : rt;
		end
		prog[progLen-1] = {opHalt, 11'b0};
	endtask

	task automatic recordWrite(input logic [2:0] dest, input logic [dataWidth-1:0] value);
		modelRegs[dest] = value;
		expReg.push_back(dest);
		expData.push_back(value);
		modelWrites++;
	endtask

	// Runs one instruction at a time
	task automatic runModel;
		logic [dataWidth-1:0] ins, a, b, imm, ea;
		logic [4:0] op;
		logic [2:0] rs, rt, rd;
		int addr;
		for (int r = 0; r < 8; r++) begin
			modelRegs[r] = '0;
		end
		for (int m = 0; m < memDepth; m++) begin
			modelMem[m] = '0;
		end
		for (int i = 0; i < progLen; i++) begin
			ins = prog[i];
			op = ins[15:11];
			rs = ins[10:8];
			rt = ins[7:5];
			rd = ins[4:2];
			imm = {{11{ins[4]}}, ins[4:0]};
			a = modelRegs[rs];
			b = modelRegs[rt];
			ea = a + imm;
			// Word address wraps at the memory depth
			addr = ea % memDepth;
			case (op)
				opAdd: recordWrite(rd, a + b);
				opSub: recordWrite(rd, a - b);
				opAnd: recordWrite(rd, a & b);
				opXor: recordWrite(rd, a ^ b);
				opAddi: recordWrite(rt, ea);
				opLd: recordWrite(rt, modelMem[addr]);
				opSt: modelMem[addr] = b;
				default: ;
			endcase
		end
	endtask

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		seed = 40308;
		wbCount = 0;
		modelWrites = 0;
		buildProgram();
		runModel();
		// Reset held for 10 rising edges
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 0);
			checkValue("halted", halted, 0);
			checkValue("instrAddr", instrAddr, 0);
		end
		rst = 1'b0;
		cycles = 0;
		// Compare each writeback until HALT retires
		while (!halted) begin
			@(negedge clk);
			cycles++;
			if (cycles == 1) begin
				checkValue("wbValid", wbValid, 0);
				checkValue("halted", halted, 0);
			end
			if (wbValid && expReg.size() == 0) begin
				abortRun("Writeback seen after all expected writes were done");
			end else if (wbValid) begin
				checkValue("wbReg", wbReg, expReg.pop_front());
				checkValue("wbData", wbData, expData.pop_front());
				wbCount++;
			end
			if (!halted && cycles >= haltLimit) begin
				abortRun("halted did not rise within 1000 cycles of reset release");
			end
		end
		// Nothing retires after HALT
		for (int c = 0; c < quietCycles; c++) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 0);
			checkValue("halted", halted, 1);
		end
		checkValue("wbCount", wbCount, modelWrites);
		// Final architectural registers
		for (int r = 0; r < 8; r++) begin
			checkValue($sformatf("regs[%0d]", r), UUT.coreInst.regFileInst.regs[r], modelRegs[r]);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
	parameter int dataDepth = 64
) (
	input  logic clk,
	input  logic rst,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	input  logic [cpuPkg::dataWidth-1:0] instrData,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic halted
);
	import cpuPkg::*;

	// Core to data RAM
	logic [dataWidth-1:0] memAddr, memWrData, memRdData;
	logic memWrEn;

	pipelineCore coreInst (
		.clk(clk),
		.rst(rst),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.memAddr(memAddr),
		.memWrEn(memWrEn),
		.memWrData(memWrData),
		.memRdData(memRdData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted)
	);

	// Depth set here only
	dataMemory #(
		.dataDepth(dataDepth)
	) dataMemInst (
		.clk(clk),
		.rst(rst),
		.addr(memAddr),
		.wrEn(memWrEn),
		.wrData(memWrData),
		.rdData(memRdData)
	);

endmodule

// ==== hw/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory #(
	parameter int dataDepth = 64
) (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::dataWidth-1:0] addr,
	input  logic wrEn,
	input  logic [cpuPkg::dataWidth-1:0] wrData,
	output logic [cpuPkg::dataWidth-1:0] rdData
);
	import cpuPkg::*;

	localparam int idxWidth = (dataDepth > 1) ? $clog2(dataDepth) : 1;

	logic [dataWidth-1:0] mem [dataDepth];
	logic [idxWidth-1:0] wordIdx;

	// Word address wraps around the array
	assign wordIdx = idxWidth'(addr % dataDepth);

	// Combinational read
	assign rdData = mem[wordIdx];

	// Write lands at the edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dataDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (wrEn) begin
			mem[wordIdx] <= wrData;
		end
	end

endmodule

// ==== hw/pipelineCore.sv ====
`timescale 1ns/1ps

module pipelineCore (
	input  logic clk,
	input  logic rst,
	output logic [cpuPkg::dataWidth-1:0] instrAddr,
	input  logic [cpuPkg::dataWidth-1:0] instrData,
	output logic [cpuPkg::dataWidth-1:0] memAddr,
	output logic memWrEn,
	output logic [cpuPkg::dataWidth-1:0] memWrData,
	input  logic [cpuPkg::dataWidth-1:0] memRdData,
	output logic wbValid,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic halted
);
	import cpuPkg::*;

	localparam logic [dataWidth-1:0] nopInstr = {opNop, {(dataWidth - opWidth){1'b0}}};

	// Fetch
	logic [dataWidth-1:0] pc;
	logic fetchStop;
	logic [dataWidth-1:0] ifIdInstr;

	// Decode
	logic [opWidth-1:0] opcode;
	logic [regAddrWidth-1:0] rs, rt, rd, decDest;
	logic [dataWidth-1:0] immExt, rsData, rtData;
	aluOp decAluOp;
	logic decUseImm, decRegWrite, decMemRead, decMemWrite, decHalt;
	logic readingRs, readingRt;
	logic stall, pcWriteEnable, ifIdWriteEnable;

	// ID/EX
	logic idExRegWrite, idExMemRead, idExMemWrite, idExHalt;
	aluOp idExAluOp;
	logic idExUseImm;
	logic [dataWidth-1:0] idExA, idExB, idExImm;
	logic [regAddrWidth-1:0] idExDest;
	logic [dataWidth-1:0] aluB, aluResult;

	// EX/MEM
	logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemHalt;
	logic [dataWidth-1:0] exMemResult, exMemStoreData;
	logic [regAddrWidth-1:0] exMemDest;

	// MEM/WB
	logic memWbRegWrite, memWbHalt;
	logic [dataWidth-1:0] memWbData;
	logic [regAddrWidth-1:0] memWbDest;

	assign instrAddr = pc;

	// PC and IF/ID freeze on stall and take NOP once HALT is seen
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			fetchStop <= 1'b0;
			ifIdInstr <= nopInstr;
		end else begin
			if (decHalt) begin
				fetchStop <= 1'b1;
			end
			if (pcWriteEnable && !fetchStop && !decHalt) begin
				pc <= pc + 16'd1;
			end
			if (ifIdWriteEnable) begin
				ifIdInstr <= (fetchStop || decHalt) ? nopInstr : instrData;
			end
		end
	end

	// Field split
	assign opcode = ifIdInstr[opMsb:opLsb];
	assign rs = ifIdInstr[rsMsb:rsLsb];
	assign rt = ifIdInstr[rtMsb:rtLsb];
	assign rd = ifIdInstr[rdMsb:rdLsb];
	assign immExt = {{(dataWidth - immMsb - 1){ifIdInstr[immMsb]}}, ifIdInstr[immMsb:0]};

	// Unknown opcodes decode as NOP
	always_comb begin
		decAluOp = aluAdd;
		decUseImm = 1'b0;
		decRegWrite = 1'b0;
		decMemRead = 1'b0;
		decMemWrite = 1'b0;
		decHalt = 1'b0;
		decDest = rd;
		readingRs = 1'b0;
		readingRt = 1'b0;
		case (opcode)
			opAdd, opSub, opAnd, opXor: begin
				decAluOp = (opcode == opAdd) ? aluAdd :
					(opcode == opSub) ? aluSub :
					(opcode == opAnd) ? aluAnd : aluXor;
				decRegWrite = 1'b1;
				readingRs = 1'b1;
				readingRt = 1'b1;
			end
			opAddi, opLd: begin
				decUseImm = 1'b1;
				decRegWrite = 1'b1;
				decMemRead = (opcode == opLd);
				// I-type destination is Rt
				decDest = rt;
				readingRs = 1'b1;
			end
			opSt: begin
				decUseImm = 1'b1;
				decMemWrite = 1'b1;
				readingRs = 1'b1;
				readingRt = 1'b1;
			end
			opHalt: begin
				decHalt = 1'b1;
			end
			default: begin
				decHalt = 1'b0;
			end
		endcase
	end

	hazardDetector hazardInst (
		.ifIdRs(rs),
		.ifIdRt(rt),
		.idExWriteReg(idExDest),
		.exMemWriteReg(exMemDest),
		.memWbWriteReg(memWbDest),
		.readingRs(readingRs),
		.readingRt(readingRt),
		.idExRegWrite(idExRegWrite),
		.exMemRegWrite(exMemRegWrite),
		.memWbRegWrite(memWbRegWrite),
		.stall(stall),
		.pcWriteEnable(pcWriteEnable),
		.ifIdWriteEnable(ifIdWriteEnable)
	);

	// Writeback drives the write port
	regFile regFileInst (
		.clk(clk),
		.rst(rst),
		.readAddrA(rs),
		.readAddrB(rt),
		.writeAddr(memWbDest),
		.writeEn(memWbRegWrite),
		.writeData(memWbData),
		.readDataA(rsData),
		.readDataB(rtData)
	);

	// ID/EX control gets a bubble on stall
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			idExRegWrite <= 1'b0;
			idExMemRead <= 1'b0;
			idExMemWrite <= 1'b0;
			idExHalt <= 1'b0;
		end else begin
			idExRegWrite <= decRegWrite;
			idExMemRead <= decMemRead;
			idExMemWrite <= decMemWrite;
			idExHalt <= decHalt;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		idExAluOp <= decAluOp;
		idExUseImm <= decUseImm;
		idExA <= rsData;
		idExB <= rtData;
		idExImm <= immExt;
		idExDest <= decDest;
	end

	// Execute
	assign aluB = idExUseImm ? idExImm : idExB;

	aluUnit aluInst (
		.op(idExAluOp),
		.operandA(idExA),
		.operandB(aluB),
		.result(aluResult)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			exMemRegWrite <= 1'b0;
			exMemMemRead <= 1'b0;
			exMemMemWrite <= 1'b0;
			exMemHalt <= 1'b0;
		end else begin
			exMemRegWrite <= idExRegWrite;
			exMemMemRead <= idExMemRead;
			exMemMemWrite <= idExMemWrite;
			exMemHalt <= idExHalt;
		end
		exMemResult <= aluResult;
		exMemStoreData <= idExB;
		exMemDest <= idExDest;
	end

	// ALU result is the data word address
	assign memAddr = exMemResult;
	assign memWrEn = exMemMemWrite;
	assign memWrData = exMemStoreData;

	always_ff @(posedge clk) begin
		if (rst) begin
			memWbRegWrite <= 1'b0;
			memWbHalt <= 1'b0;
			halted <= 1'b0;
		end else begin
			memWbRegWrite <= exMemRegWrite;
			memWbHalt <= exMemHalt;
			// Sticky until reset
			if (memWbHalt) begin
				halted <= 1'b1;
			end
		end
		memWbData <= exMemMemRead ? memRdData : exMemResult;
		memWbDest <= exMemDest;
	end

	// Writeback outputs
	assign wbValid = memWbRegWrite;
	assign wbReg = memWbDest;
	assign wbData = memWbData;

	// A stalled decode holds the PC and IF/ID for the next cycle
	stallFreezesFetch: assert property (
		@(posedge clk) disable iff (rst)
		stall |=> ($stable(pc) && $stable(ifIdInstr))
	);

	// Fetch was frozen well before HALT retired
	pcStableWhileHalted: assert property (
		@(posedge clk) disable iff (rst)
		(halted && !rst) |=> $stable(pc)
	);

endmodule

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input  cpuPkg::aluOp op,
	input  logic [cpuPkg::dataWidth-1:0] operandA,
	input  logic [cpuPkg::dataWidth-1:0] operandB,
	output logic [cpuPkg::dataWidth-1:0] result
);
	import cpuPkg::*;

	// Pure combinational datapath
	always_comb begin
		case (op)
			// Also ADDI and LD/ST effective address
			aluAdd: begin
				result = operandA + operandB;
			end
			aluSub: begin
				result = operandA - operandB;
			end
			aluAnd: begin
				result = operandA & operandB;
			end
			aluXor: begin
				result = operandA ^ operandB;
			end
			// Unreachable for a clean select, keep it defined
			default: begin
				result = operandA + operandB;
			end
		endcase
	end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
	input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
	input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	input  logic writeEn,
	input  logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readDataA,
	output logic [cpuPkg::dataWidth-1:0] readDataB
);
	import cpuPkg::*;

	localparam int numRegs = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [numRegs];

	// Write port, whole file cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through so decode sees the value being written this cycle
	assign readDataA = (writeEn && (writeAddr == readAddrA)) ? writeData : regs[readAddrA];
	assign readDataB = (writeEn && (writeAddr == readAddrB)) ? writeData : regs[readAddrB];

	// Writeback must never target an unknown register
	writeAddrKnown: assert property (
		@(posedge clk) disable iff (rst)
		writeEn |-> !$isunknown(writeAddr)
	);

endmodule

// ==== hw/hazardDetector.sv ====
`timescale 1ns/1ps

module hazardDetector (
	input  logic [cpuPkg::regAddrWidth-1:0] ifIdRs,
	input  logic [cpuPkg::regAddrWidth-1:0] ifIdRt,
	input  logic [cpuPkg::regAddrWidth-1:0] idExWriteReg,
	input  logic [cpuPkg::regAddrWidth-1:0] exMemWriteReg,
	input  logic [cpuPkg::regAddrWidth-1:0] memWbWriteReg,
	input  logic readingRs,
	input  logic readingRt,
	input  logic idExRegWrite,
	input  logic exMemRegWrite,
	input  logic memWbRegWrite,
	output logic stall,
	output logic pcWriteEnable,
	output logic ifIdWriteEnable
);

	logic idExRawRs, idExRawRt;
	logic exMemRawRs, exMemRawRt;
	logic memWbRawRs, memWbRawRt;
	logic idExStall, exMemStall, memWbStall;

	// Rs is bits 10..8 of the decode instruction
	// Rt is bits 7..5 and only checked when actually read
	assign idExRawRs = (idExWriteReg == ifIdRs) & readingRs;
	assign idExRawRt = (idExWriteReg == ifIdRt) & readingRt;

	assign exMemRawRs = (exMemWriteReg == ifIdRs) & readingRs;
	assign exMemRawRt = (exMemWriteReg == ifIdRt) & readingRt;

	// No bypass paths, so writeback stage counts too
	assign memWbRawRs = (memWbWriteReg == ifIdRs) & readingRs;
	assign memWbRawRt = (memWbWriteReg == ifIdRt) & readingRt;

	// A stage only blocks decode if it really writes a register
	assign idExStall = idExRegWrite & (idExRawRs | idExRawRt);
	assign exMemStall = exMemRegWrite & (exMemRawRs | exMemRawRt);
	assign memWbStall = memWbRegWrite & (memWbRawRs | memWbRawRt);

	assign stall = idExStall | exMemStall | memWbStall;
	// Freeze PC and IF/ID together
	assign pcWriteEnable = ~stall;
	assign ifIdWriteEnable = ~stall;

endmodule

// ==== hw/cpuPkg.sv ====
package cpuPkg;

	// Word and register address sizes
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;
	localparam int opWidth = 5;

	// Instruction field positions
	localparam int opMsb = 15;
	localparam int opLsb = 11;
	localparam int rsMsb = 10;
	localparam int rsLsb = 8;
	localparam int rtMsb = 7;
	localparam int rtLsb = 5;
	localparam int rdMsb = 4;
	localparam int rdLsb = 2;
	// imm5 sits in the low bits, sign-extended
	localparam int immMsb = 4;

	// Opcodes, all-zero word decodes as NOP
	localparam logic [opWidth-1:0] opNop = 5'b00000;
	localparam logic [opWidth-1:0] opAdd = 5'b00001;
	localparam logic [opWidth-1:0] opSub = 5'b00010;
	localparam logic [opWidth-1:0] opAnd = 5'b00011;
	localparam logic [opWidth-1:0] opXor = 5'b00100;
	localparam logic [opWidth-1:0] opAddi = 5'b00101;
	localparam logic [opWidth-1:0] opLd = 5'b00110;
	localparam logic [opWidth-1:0] opSt = 5'b00111;
	localparam logic [opWidth-1:0] opHalt = 5'b11111;

	// ALU function select
	typedef enum logic [1:0] {
		aluAdd = 2'b00,
		aluSub = 2'b01,
		aluAnd = 2'b10,
		aluXor = 2'b11
	} aluOp;

endpackage
